// ==== sources.f ====
rtl/conv_cfg_pkg.sv
rtl/conv_load_pkg.sv
rtl/conv_load_sequencer.sv
rtl/conv_loop_nest.sv
rtl/conv_load_addr.sv
rtl/conv_load_controller.sv
tb/conv_load_sva.sv
tb/tb_conv_load_controller.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator and run the load controller testbench

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module tb_conv_load_controller -Mdir obj_dir -f sources.f; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_conv_load_controller > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Finished with no errors" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

// ==== tb/tb_conv_load_controller.sv ====
`timescale 1ns/1ps

module tb_conv_load_controller;
    import conv_cfg_pkg::*;
    import conv_load_pkg::*;

    typedef struct packed {
        conv_cfg_t cfg;
        idx_t      n_adr;
        idx_t      n_tile;
    } test_row_t;

    // buffer side view of one returned beat
    typedef struct packed {
        addr_t    adr;
        buf_idx_t idx;
        logic     tile;
        logic     tile0;
        logic     tilen;
    } beat_t;

    logic      clk;
    logic      reset;
    conv_cfg_t cfg;
    logic      load_ddr_start;
    logic      load_ddr_continue;
    logic      valid_load_data;
    addr_t     ddr_adr;
    logic      ddr_adr_valid;
    buf_idx_t  buf_idx;
    addr_t     buf_adr;
    logic      tile_fin;
    logic      tile0_fin;
    logic      tilen_fin;

    test_row_t tests [4];
    addr_t     exp_ddr[$];
    beat_t     exp_beat[$];
    integer    seed = 32'h1a9a_6c67;
    int        errors = 0;
    int        cycles = 0;
    int        limit;

    conv_load_controller u_conv_load_controller (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit)
            report_error($sformatf("Timeout: run not finished after %0d cycles", limit));
    end

    ////////////////////
    // checks
    ////////////////////

    task automatic report_error(input string msg);
        errors++;
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_adr(input string what, input addr_t got, input addr_t exp);
        if (got !== exp)
            report_error($sformatf("Mismatch at %0t: %s expected %h, got %h",
                $time, what, exp, got));
    endtask

    task automatic check_idx(input string what, input buf_idx_t got, input buf_idx_t exp);
        if (got !== exp)
            report_error($sformatf("Mismatch at %0t: %s expected %0d, got %0d",
                $time, what, exp, got));
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp)
            report_error($sformatf("Mismatch at %0t: %s expected %b, got %b",
                $time, what, exp, got));
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp)
            report_error($sformatf("Mismatch at %0t: %s expected %0d, got %0d",
                $time, what, exp, got));
    endtask

    ////////////////////
    // reference model
    ////////////////////

    function automatic addr_t model_adr(conv_cfg_t c, idx_t row, idx_t beg, idx_t tif);
        int col_sh;
        int row_sh;
        col_sh = int'(c.nif_log2) - 1;
        row_sh = col_sh + int'(c.ix_log2) - 5;
        return addr_t'((32'(row) << row_sh) + ((32'(beg) << col_sh) >> 5)
            + (32'(tif - 16'd1) >> 1));
    endfunction

    // walks the loop rule one beat at a time
    task automatic build_model(input conv_cfg_t c);
        idx_t  tif;
        idx_t  sx;
        idx_t  by;
        idx_t  sy;
        idx_t  tx;
        idx_t  ty;
        idx_t  rc;
        idx_t  row;
        idx_t  brow;
        idx_t  beg;
        idx_t  rend;
        idx_t  step_y;
        logic  e_f;
        logic  e_x;
        logic  e_b;
        logic  e_s;
        logic  e_t;
        logic  e_y;
        beat_t b;
        exp_ddr.delete();
        exp_beat.delete();
        tif = 16'd1;
        sx = 16'd1;
        by = 16'd1;
        sy = 16'd1;
        tx = 16'd1;
        ty = 16'd1;
        rc = 16'd0;
        step_y = 16'd3 * idx_t'(c.stride);
        e_y = 1'b0;
        while (!e_y) begin
            row = (ty - 16'd1) + 16'd3 * (sy - 16'd1) + (by - 16'd1);
            brow = (c.stride == 4'd1) ? rc + sy - 16'd1 : (rc << 1) + sy - 16'd1;
            beg = (tx - 16'd1) + ((sx - 16'd1) << 5);
            rend = beg + c.tile_cols - 16'd1;
            if (rend > c.ix - 16'd1)
                rend = c.ix - 16'd1;
            e_f = tif + 16'd1 >= c.nif;
            e_x = e_f && (sx == c.row_words || rend == c.ix);
            e_b = e_x && (by == 16'd3 || row == c.iy);
            e_s = e_b && (sy == idx_t'(c.stride) || row == c.iy);
            e_t = e_s && (tx + c.tile_cols - 16'd1 >= c.ix);
            e_y = e_t && (ty + step_y - 16'd1 >= c.iy || row == c.iy);
            exp_ddr.push_back(model_adr(c, row, beg, tif));
            b.adr   = model_adr(c, brow, beg, tif);
            b.idx   = buf_idx_t'(by);
            b.tile  = e_s;
            b.tile0 = e_s && ty == 16'd1 && tx == 16'd1;
            b.tilen = e_s && ty > 16'd1 && tx > 16'd1;
            exp_beat.push_back(b);
            if (e_t) begin
                ty = e_y ? 16'd1 : ty + step_y;
                rc = e_y ? 16'd0 : rc + 16'd1;
            end
            if (e_s)
                tx = e_t ? 16'd1 : tx + c.tile_cols;
            if (e_b)
                sy = e_s ? 16'd1 : sy + 16'd1;
            if (e_x)
                by = e_b ? 16'd1 : by + 16'd1;
            if (e_f)
                sx = e_x ? 16'd1 : sx + 16'd1;
            tif = e_f ? 16'd1 : tif + 16'd2;
        end
    endtask

    ////////////////////
    // one table row
    ////////////////////

    task automatic run_test(input test_row_t t);
        int    issued;
        int    consumed;
        int    tiles;
        int    cont_wait;
        logic  stall_exp;
        logic  tilen_seen;
        logic  cont_sent;
        beat_t b;
        build_model(t.cfg);
        check_count("model address count", exp_ddr.size(), int'(t.n_adr));
        @(posedge clk);
        #2;
        reset = 1'b1;
        cfg = t.cfg;
        valid_load_data = 1'b0;
        load_ddr_continue = 1'b0;
        repeat (8) @(posedge clk);
        #2;
        reset = 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_flag("ddr_adr_valid before start", ddr_adr_valid, 1'b0);
            check_flag("tile flags before start", tile_fin | tile0_fin | tilen_fin, 1'b0);
        end
        @(posedge clk);
        #2;
        load_ddr_start = 1'b1;
        @(negedge clk);
        check_flag("ddr_adr_valid in start cycle", ddr_adr_valid, 1'b0);
        issued = 0;
        consumed = 0;
        tiles = 0;
        cont_wait = 0;
        stall_exp = 1'b0;
        tilen_seen = 1'b0;
        cont_sent = 1'b0;
        while (consumed < exp_beat.size() || issued < exp_ddr.size()) begin
            @(posedge clk);
            #2;
            load_ddr_start = 1'b0;
            // stall follows tilen_fin and continue by one cycle
            if (tilen_seen)
                stall_exp = 1'b1;
            else if (cont_sent)
                stall_exp = 1'b0;
            cont_sent = (cont_wait == 1);
            if (cont_wait > 0)
                cont_wait--;
            load_ddr_continue = cont_sent;
            valid_load_data = (consumed < issued) && (($random(seed) & 3) != 0);
            @(negedge clk);
            check_flag("ddr_adr_valid", ddr_adr_valid, issued < exp_ddr.size() && !stall_exp);
            if (ddr_adr_valid) begin
                check_adr("ddr_adr", ddr_adr, exp_ddr[issued]);
                issued++;
            end
            b = valid_load_data ? exp_beat[consumed] : '0;
            check_flag("tile_fin", tile_fin, b.tile);
            check_flag("tile0_fin", tile0_fin, b.tile0);
            check_flag("tilen_fin", tilen_fin, b.tilen);
            if (valid_load_data) begin
                check_idx("buf_idx", buf_idx, b.idx);
                check_adr("buf_adr", buf_adr, b.adr);
                consumed++;
            end
            tiles += int'(b.tile);
            tilen_seen = b.tilen;
            if (tilen_seen)
                cont_wait = 3;
        end
        check_count("tile count", tiles, int'(t.n_tile));
    endtask

    initial begin
        // stride, ix, iy, nif, nif_log2, ix_log2, tile_cols, row_words, then addresses, tiles
        tests[0] = '{'{4'd1, 16'd63, 16'd6, 16'd4, 4'd2, 4'd6, 16'd32, 16'd1}, 16'd24, 16'd4};
        tests[1] = '{'{4'd2, 16'd96, 16'd9, 16'd3, 4'd2, 4'd7, 16'd32, 16'd1}, 16'd60, 16'd6};
        tests[2] = '{'{4'd1, 16'd64, 16'd6, 16'd4, 4'd2, 4'd6, 16'd64, 16'd2}, 16'd24, 16'd2};
        tests[3] = '{'{4'd1, 16'd96, 16'd9, 16'd3, 4'd2, 4'd7, 16'd32, 16'd1}, 16'd54, 16'd9};
        limit = 200;
        foreach (tests[i])
            limit += 20 * (int'(tests[i].n_adr) + int'(tests[i].n_tile));
        reset = 1'b1;
        cfg = tests[0].cfg;
        load_ddr_start = 1'b0;
        load_ddr_continue = 1'b0;
        valid_load_data = 1'b0;
        foreach (tests[i])
            run_test(tests[i]);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== tb/conv_load_sva.sv ====
`timescale 1ns/1ps

module conv_load_sva (
    input logic clk,
    input logic reset,
    input logic ddr_adr_valid,
    input logic tile_fin,
    input logic tile0_fin,
    input logic tilen_fin
);

    ////////////////////
    // quiet during reset
    ////////////////////

    // first reset cycle still sees power-up state
    a_no_valid_in_reset: assert property (@(posedge clk)
        $past(reset) && reset |-> !ddr_adr_valid)
        else $error("ddr_adr_valid high during reset");

    a_no_flags_in_reset: assert property (@(posedge clk)
        $past(reset) && reset |-> !(tile_fin || tile0_fin || tilen_fin))
        else $error("tile flag high during reset");

    ////////////////////
    // tile flags
    ////////////////////

    a_first_or_later: assert property (@(posedge clk) disable iff (reset)
        !(tile0_fin && tilen_fin))
        else $error("tile0_fin and tilen_fin high together");

    a_tile0_is_tile: assert property (@(posedge clk) disable iff (reset)
        tile0_fin |-> tile_fin)
        else $error("tile0_fin without tile_fin");

    a_tilen_is_tile: assert property (@(posedge clk) disable iff (reset)
        tilen_fin |-> tile_fin)
        else $error("tilen_fin without tile_fin");

endmodule

bind conv_load_controller conv_load_sva u_sva (
    .clk           (clk),
    .reset         (reset),
    .ddr_adr_valid (ddr_adr_valid),
    .tile_fin      (tile_fin),
    .tile0_fin     (tile0_fin),
    .tilen_fin     (tilen_fin)
);

// ==== rtl/conv_load_controller.sv ====
`timescale 1ns/1ps

module conv_load_controller (
    input  logic                    clk,
    input  logic                    reset,
    input  conv_cfg_pkg::conv_cfg_t cfg,
    input  logic                    load_ddr_start,
    input  logic                    load_ddr_continue,
    input  logic                    valid_load_data,
    output conv_load_pkg::addr_t    ddr_adr,
    output logic                    ddr_adr_valid,
    output conv_load_pkg::buf_idx_t buf_idx,
    output conv_load_pkg::addr_t    buf_adr,
    output logic                    tile_fin,
    output logic                    tile0_fin,
    output logic                    tilen_fin
);
    import conv_cfg_pkg::*;
    import conv_load_pkg::*;

    conv_cfg_t cfg_q;
    logic      ddr_step;

    loop_pos_t ddr_pos;
    loop_evt_t ddr_evt;
    loop_pos_t buf_pos;
    loop_evt_t buf_evt;

    conv_load_sequencer u_sequencer (
        .clk               (clk),
        .reset             (reset),
        .cfg               (cfg),
        .load_ddr_start    (load_ddr_start),
        .load_ddr_continue (load_ddr_continue),
        .ddr_pass_end      (ddr_evt.pass_end),
        .buf_evt           (buf_evt),
        .buf_pos           (buf_pos),
        .cfg_q             (cfg_q),
        .ddr_step          (ddr_step),
        .tile_fin          (tile_fin),
        .tile0_fin         (tile0_fin),
        .tilen_fin         (tilen_fin)
    );

    ////////////////////
    // ddr side
    ////////////////////

    conv_loop_nest u_ddr_nest (
        .clk   (clk),
        .reset (reset),
        .cfg   (cfg_q),
        .step  (ddr_step),
        .pos   (ddr_pos),
        .evt   (ddr_evt)
    );

    conv_load_addr #(.buf_side(1'b0)) u_ddr_addr (
        .cfg (cfg_q),
        .pos (ddr_pos),
        .adr (ddr_adr)
    );

    assign ddr_adr_valid = ddr_step;

    ////////////////////
    // buffer side
    ////////////////////

    // advances once per returned beat
    conv_loop_nest u_buf_nest (
        .clk   (clk),
        .reset (reset),
        .cfg   (cfg_q),
        .step  (valid_load_data),
        .pos   (buf_pos),
        .evt   (buf_evt)
    );

    conv_load_addr #(.buf_side(1'b1)) u_buf_addr (
        .cfg (cfg_q),
        .pos (buf_pos),
        .adr (buf_adr)
    );

    assign buf_idx = buf_idx_t'(buf_pos.bufy);

endmodule

// ==== rtl/conv_load_addr.sv ====
`timescale 1ns/1ps

module conv_load_addr #(
    parameter bit buf_side = 1'b0
) (
    input  conv_cfg_pkg::conv_cfg_t  cfg,
    input  conv_load_pkg::loop_pos_t pos,
    output conv_load_pkg::addr_t     adr
);
    import conv_cfg_pkg::*;
    import conv_load_pkg::*;

    idx_t        buf_row;
    idx_t        row;
    shift_t      row_sh;
    shift_t      col_sh;
    logic [31:0] row_term;
    logic [31:0] col_term;
    logic [31:0] fm_term;

    ////////////////////
    // row selection
    ////////////////////

    // row inside the three line buffers, only stride 1 and 2 exist
    always_comb begin
        case (cfg.stride)
            4'd1:    buf_row = pos.row_cnt + pos.siy - 16'd1;
            4'd2:    buf_row = (pos.row_cnt << 1) + pos.siy - 16'd1;
            default: buf_row = '0;
        endcase
    end

    assign row = buf_side ? buf_row : row_index(pos);

    ////////////////////
    // address terms
    ////////////////////

    // words per feature-map group, scaled to one full row
    assign col_sh = cfg.nif_log2 - shift_t'(ifs_in_row_log2);
    assign row_sh = col_sh + cfg.ix_log2 - shift_t'(pixels_in_row_log2);

    assign row_term = 32'(row) << row_sh;

    // wide so the left shift keeps its upper bits before dropping to words
    assign col_term = (32'(row_start(pos)) << col_sh) >> pixels_in_row_log2;

    assign fm_term = 32'(pos.tif - 16'd1) >> ifs_in_row_log2;

    assign adr = addr_t'(row_term + col_term + fm_term);

endmodule

// ==== rtl/conv_loop_nest.sv ====
`timescale 1ns/1ps

module conv_loop_nest (
    input  logic                     clk,
    input  logic                     reset,
    input  conv_cfg_pkg::conv_cfg_t  cfg,
    input  logic                     step,
    output conv_load_pkg::loop_pos_t pos,
    output conv_load_pkg::loop_evt_t evt
);
    import conv_cfg_pkg::*;
    import conv_load_pkg::*;

    idx_t tif;
    idx_t sparex;
    idx_t bufy;
    idx_t siy;
    idx_t tix;
    idx_t tiy;
    idx_t row_cnt;

    idx_t row_idx;
    idx_t row_beg;
    idx_t row_end;
    idx_t tile_end;

    logic tif_end;
    logic sparex_end;
    logic bufy_end;
    logic siy_end;
    logic tix_end;
    logic tiy_end;

    assign pos = '{
        tif:     tif,
        sparex:  sparex,
        bufy:    bufy,
        siy:     siy,
        tix:     tix,
        tiy:     tiy,
        row_cnt: row_cnt
    };

    ////////////////////
    // derived positions
    ////////////////////

    assign row_idx  = row_index(pos);
    assign row_beg  = row_start(pos);
    assign tile_end = row_beg + cfg.tile_cols - 16'd1;

    // clipped to the last pixel of the row
    assign row_end = (tile_end >= cfg.ix) ? cfg.ix - 16'd1 : tile_end;

    ////////////////////
    // end conditions, innermost first
    ////////////////////

    assign tif_end = step
        && (tif + idx_t'(ddr_load_ratio) - 16'd1 >= cfg.nif);

    assign sparex_end = tif_end
        && ((sparex == cfg.row_words) || (row_end == cfg.ix));

    assign bufy_end = sparex_end
        && ((bufy == idx_t'(buffers_num)) || (row_idx == cfg.iy));

    assign siy_end = bufy_end
        && ((siy == idx_t'(cfg.stride)) || (row_idx == cfg.iy));

    assign tix_end = siy_end
        && (tix + cfg.tile_cols - 16'd1 >= cfg.ix);

    // bottom of the map also closes the pass
    assign tiy_end = tix_end
        && ((tiy + tiy_step(cfg.stride) - 16'd1 >= cfg.iy) || (row_idx == cfg.iy));

    assign evt = '{
        step:     step,
        siy_end:  siy_end,
        pass_end: tiy_end
    };

    ////////////////////
    // counters
    ////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            tif <= 16'd1;
        end else if (step) begin
            tif <= next_cnt(tif, idx_t'(ddr_load_ratio), tif_end);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sparex <= 16'd1;
        end else if (tif_end) begin
            sparex <= next_cnt(sparex, 16'd1, sparex_end);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bufy <= 16'd1;
        end else if (sparex_end) begin
            bufy <= next_cnt(bufy, 16'd1, bufy_end);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            siy <= 16'd1;
        end else if (bufy_end) begin
            siy <= next_cnt(siy, 16'd1, siy_end);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tix <= 16'd1;
        end else if (siy_end) begin
            tix <= next_cnt(tix, cfg.tile_cols, tix_end);
        end
    end

    // row_cnt follows tiy, restarting from 0
    always_ff @(posedge clk) begin
        if (reset) begin
            tiy     <= 16'd1;
            row_cnt <= '0;
        end else if (tix_end) begin
            tiy     <= next_cnt(tiy, tiy_step(cfg.stride), tiy_end);
            row_cnt <= tiy_end ? '0 : row_cnt + 16'd1;
        end
    end

endmodule

// ==== rtl/conv_load_sequencer.sv ====
`timescale 1ns/1ps

module conv_load_sequencer (
    input  logic                     clk,
    input  logic                     reset,
    input  conv_cfg_pkg::conv_cfg_t  cfg,
    input  logic                     load_ddr_start,
    input  logic                     load_ddr_continue,
    input  logic                     ddr_pass_end,
    input  conv_load_pkg::loop_evt_t buf_evt,
    input  conv_load_pkg::loop_pos_t buf_pos,
    output conv_cfg_pkg::conv_cfg_t  cfg_q,
    output logic                     ddr_step,
    output logic                     tile_fin,
    output logic                     tile0_fin,
    output logic                     tilen_fin
);

    logic run;
    logic stall;

    ////////////////////
    // configuration
    ////////////////////

    // loaded on every reset cycle, held afterwards
    always_ff @(posedge clk) begin
        if (reset) begin
            cfg_q <= cfg;
        end
    end

    ////////////////////
    // run and stall
    ////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            run <= 1'b0;
        end else if (load_ddr_start) begin
            run <= 1'b1;
        end else if (ddr_pass_end) begin
            run <= 1'b0;
        end
    end

    // a later tile must be consumed before ddr issue goes on
    always_ff @(posedge clk) begin
        if (reset) begin
            stall <= 1'b0;
        end else if (tilen_fin) begin
            stall <= 1'b1;
        end else if (load_ddr_continue) begin
            stall <= 1'b0;
        end
    end

    assign ddr_step = run && !stall;

    ////////////////////
    // tile flags
    ////////////////////

    // buffer side tile ends with its stride-row loop
    assign tile_fin = buf_evt.siy_end;

    assign tile0_fin = buf_evt.siy_end
        && (buf_pos.tiy == 16'd1)
        && (buf_pos.tix == 16'd1);

    assign tilen_fin = buf_evt.siy_end
        && (buf_pos.tiy > 16'd1)
        && (buf_pos.tix > 16'd1);

endmodule

// ==== rtl/conv_load_pkg.sv ====
package conv_load_pkg;
    import conv_cfg_pkg::*;

    typedef logic [15:0] addr_t;
    typedef logic [1:0]  buf_idx_t;

    // current position of one loop nest, counters count from 1
    typedef struct packed {
        idx_t tif;
        idx_t sparex;
        idx_t bufy;
        idx_t siy;
        idx_t tix;
        idx_t tiy;
        // tile rows done so far
        idx_t row_cnt;
    } loop_pos_t;

    typedef struct packed {
        logic step;
        logic siy_end;
        logic pass_end;
    } loop_evt_t;

    ////////////////////
    // loop step helpers
    ////////////////////

    // next value of a counter that wraps back to 1 at its end
    function automatic idx_t next_cnt(idx_t cnt, idx_t inc, logic last);
        return last ? idx_t'(1) : idx_t'(cnt + inc);
    endfunction

    // tile row advance, three buffer rows per stride row
    function automatic idx_t tiy_step(logic [3:0] stride);
        return idx_t'(buffers_num) * idx_t'(stride);
    endfunction

    // absolute input row, 0 based
    function automatic idx_t row_index(loop_pos_t p);
        return (p.tiy - idx_t'(1)) + idx_t'(buffers_num) * (p.siy - idx_t'(1))
            + (p.bufy - idx_t'(1));
    endfunction

    // first pixel of the current word in the row, 0 based
    function automatic idx_t row_start(loop_pos_t p);
        return (p.tix - idx_t'(1)) + ((p.sparex - idx_t'(1)) << pixels_in_row_log2);
    endfunction

endpackage

// ==== rtl/conv_cfg_pkg.sv ====
package conv_cfg_pkg;

    typedef logic [15:0] idx_t;
    typedef logic [3:0]  shift_t;

    ////////////////////
    // layer configuration, captured while reset is high
    ////////////////////

    typedef struct packed {
        logic [3:0] stride;
        idx_t       ix;
        idx_t       iy;
        idx_t       nif;
        shift_t     nif_log2;
        shift_t     ix_log2;
        // tile column width in pixels
        idx_t       tile_cols;
        // spare-word loop limit
        idx_t       row_words;
    } conv_cfg_t;

    ////////////////////
    // fixed engine constants
    ////////////////////

    // one row buffer per systolic array column
    localparam int unsigned buffers_num = 3;

    localparam int unsigned pixels_in_row      = 32;
    localparam int unsigned pixels_in_row_log2 = 5;

    // feature maps carried by one ddr beat
    localparam int unsigned ddr_load_ratio  = 2;
    localparam int unsigned ifs_in_row_log2 = 1;

endpackage
